//--- Makefile
VERILATOR  ?= verilator
TOP        := fetch_tb
LINT_TOP   := fetch_top
FILELIST   := all.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only -Wall --timing --timescale 1ns/1ps
SIM_FLAGS  := --binary --timing --assert --timescale 1ns/1ps -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf $(OBJ_DIR)

//--- all.f
src/fetch_pkg.sv
src/inst_memory.sv
src/i_cache.sv
src/fetch_unit.sv
src/fetch_top.sv
tests/fetch_assertions.sv
tests/fetch_tb.sv

//--- src/fetch_pkg.sv
package fetch_pkg;

    // Instruction and data words are 32 bits wide.
    typedef logic [31:0] word_t;

    // Word address, split by the cache into index and tag.
    typedef logic [15:0] addr_t;

    // Cache controller states.
    typedef enum logic [1:0] {
        st_idle,
        st_compare,
        st_allocate
    } cache_state_t;

endpackage

//--- src/fetch_top.sv
`timescale 1ns/1ps

module fetch_top #(
    parameter int INDEX_BITS  = 4,
    parameter int MEM_LATENCY = 3
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             run,
    input  logic             redirect_valid,
    input  fetch_pkg::addr_t redirect_pc,
    input  logic             flush,
    input  logic             load_en,
    input  fetch_pkg::addr_t load_addr,
    input  fetch_pkg::word_t load_data,
    output logic             inst_valid,
    output fetch_pkg::addr_t inst_pc,
    output fetch_pkg::word_t inst_data,
    output logic             busy
);
    import fetch_pkg::*;

    logic  cpu_req_valid;
    logic  cpu_req_ready;
    addr_t cpu_req_addr;
    word_t cpu_req_data;
    logic  mem_req_valid;
    logic  mem_req_ready;
    addr_t mem_req_addr;
    word_t mem_req_data;

    fetch_unit u_fetch (
        .clk            (clk),
        .rst            (rst),
        .run            (run),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .cpu_req_ready  (cpu_req_ready),
        .cpu_req_data   (cpu_req_data),
        .cpu_req_valid  (cpu_req_valid),
        .cpu_req_addr   (cpu_req_addr),
        .inst_valid     (inst_valid),
        .inst_pc        (inst_pc),
        .inst_data      (inst_data),
        .busy           (busy)
    );

    i_cache #(
        .INDEX_BITS (INDEX_BITS)
    ) u_cache (
        .clk           (clk),
        .rst           (rst),
        .cpu_req_valid (cpu_req_valid),
        .cpu_req_addr  (cpu_req_addr),
        .flush         (flush),
        .mem_req_ready (mem_req_ready),
        .mem_req_data  (mem_req_data),
        .cpu_req_ready (cpu_req_ready),
        .cpu_req_data  (cpu_req_data),
        .mem_req_valid (mem_req_valid),
        .mem_req_addr  (mem_req_addr)
    );

    inst_memory #(
        .MEM_LATENCY (MEM_LATENCY)
    ) u_mem (
        .clk           (clk),
        .rst           (rst),
        .mem_req_valid (mem_req_valid),
        .mem_req_addr  (mem_req_addr),
        .load_en       (load_en),
        .load_addr     (load_addr),
        .load_data     (load_data),
        .mem_req_ready (mem_req_ready),
        .mem_req_data  (mem_req_data)
    );

endmodule

//--- src/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
    input  logic             clk,
    input  logic             rst,
    input  logic             run,
    input  logic             redirect_valid,
    input  fetch_pkg::addr_t redirect_pc,
    input  logic             cpu_req_ready,
    input  fetch_pkg::word_t cpu_req_data,
    output logic             cpu_req_valid,
    output fetch_pkg::addr_t cpu_req_addr,
    output logic             inst_valid,
    output fetch_pkg::addr_t inst_pc,
    output fetch_pkg::word_t inst_data,
    output logic             busy
);
    import fetch_pkg::*;

    addr_t pc;
    logic  outstanding;
    logic  drop;

    assign cpu_req_valid = run && !outstanding;
    assign cpu_req_addr  = pc;
    assign busy          = outstanding;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pc          <= '0;
            outstanding <= 1'b0;
            drop        <= 1'b0;
            inst_valid  <= 1'b0;
        end
        else
        begin
            // A redirect in the ready cycle still discards the returning word.
            inst_valid <= cpu_req_ready && !drop && !redirect_valid;

            if (cpu_req_ready)
            begin
                outstanding <= 1'b0;
                drop        <= 1'b0;
            end
            else if (cpu_req_valid)
            begin
                outstanding <= 1'b1;
                drop        <= redirect_valid;
            end
            else if (redirect_valid && outstanding)
            begin
                drop <= 1'b1;
            end

            if (redirect_valid)
                pc <= redirect_pc;
            else if (cpu_req_ready && !drop)
                pc <= pc + addr_t'(1);
        end
    end

    // The pc only moves on a kept result, so it still names the word that returns.
    always_ff @(posedge clk)
    begin
        if (cpu_req_ready)
        begin
            inst_pc   <= pc;
            inst_data <= cpu_req_data;
        end
    end

endmodule

//--- src/i_cache.sv
`timescale 1ns/1ps

module i_cache #(
    parameter int INDEX_BITS = 4
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             cpu_req_valid,
    input  fetch_pkg::addr_t cpu_req_addr,
    input  logic             flush,
    input  logic             mem_req_ready,
    input  fetch_pkg::word_t mem_req_data,
    output logic             cpu_req_ready,
    output fetch_pkg::word_t cpu_req_data,
    output logic             mem_req_valid,
    output fetch_pkg::addr_t mem_req_addr
);
    import fetch_pkg::*;

    localparam int LINES    = 1 << INDEX_BITS;
    localparam int TAG_BITS = $bits(addr_t) - INDEX_BITS;

    typedef logic [INDEX_BITS-1:0] index_t;
    typedef logic [TAG_BITS-1:0]   tag_t;

    cache_state_t       state;
    addr_t              req_addr;
    logic [LINES-1:0]   valid_bits;
    tag_t               tag_mem [LINES];
    word_t              data_mem [LINES];
    index_t             req_index;
    tag_t               req_tag;
    logic               hit;

    assign req_index = req_addr[INDEX_BITS-1:0];
    assign req_tag   = req_addr[$bits(addr_t)-1:INDEX_BITS];
    assign hit       = valid_bits[req_index] && (tag_mem[req_index] == req_tag);

    // A fill always targets the latched request address.
    assign mem_req_addr = req_addr;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state         <= st_idle;
            valid_bits    <= '0;
            cpu_req_ready <= 1'b0;
            mem_req_valid <= 1'b0;
        end
        else
        begin
            cpu_req_ready <= 1'b0;
            case (state)
                st_idle:
                begin
                    if (flush)
                        valid_bits <= '0;
                    if (cpu_req_valid)
                        state <= st_compare;
                end
                st_compare:
                begin
                    if (hit)
                    begin
                        cpu_req_ready <= 1'b1;
                        state         <= st_idle;
                    end
                    else
                    begin
                        mem_req_valid <= 1'b1;
                        state         <= st_allocate;
                    end
                end
                // After the fill the controller compares again, which now hits.
                st_allocate:
                begin
                    if (mem_req_ready)
                    begin
                        valid_bits[req_index] <= 1'b1;
                        mem_req_valid         <= 1'b0;
                        state                 <= st_compare;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == st_idle && cpu_req_valid)
            req_addr <= cpu_req_addr;
        if (state == st_compare && hit)
            cpu_req_data <= data_mem[req_index];
        if (state == st_allocate && mem_req_ready)
        begin
            tag_mem[req_index]  <= req_tag;
            data_mem[req_index] <= mem_req_data;
        end
    end

endmodule

//--- src/inst_memory.sv
`timescale 1ns/1ps

module inst_memory #(
    parameter int MEM_LATENCY = 3
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             mem_req_valid,
    input  fetch_pkg::addr_t mem_req_addr,
    input  logic             load_en,
    input  fetch_pkg::addr_t load_addr,
    input  fetch_pkg::word_t load_data,
    output logic             mem_req_ready,
    output fetch_pkg::word_t mem_req_data
);
    import fetch_pkg::*;

    localparam int CNT_BITS = $clog2(MEM_LATENCY + 1);

    typedef enum logic [1:0] {
        mem_idle,
        mem_count,
        mem_hold
    } mem_state_t;

    word_t                mem [65536];
    mem_state_t           state;
    logic [CNT_BITS-1:0]  cnt;
    logic                 accept;
    logic                 fire;

    assign accept = (state == mem_idle) && mem_req_valid;

    // The response leaves on the edge that completes MEM_LATENCY cycles of waiting.
    assign fire = (accept && MEM_LATENCY == 1) ||
                  (state == mem_count && cnt == CNT_BITS'(MEM_LATENCY - 1));

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state         <= mem_idle;
            cnt           <= '0;
            mem_req_ready <= 1'b0;
        end
        else
        begin
            mem_req_ready <= fire;
            case (state)
                mem_idle:
                begin
                    cnt <= CNT_BITS'(1);
                    if (accept)
                        state <= fire ? mem_hold : mem_count;
                end
                mem_count:
                begin
                    cnt <= cnt + CNT_BITS'(1);
                    if (fire)
                        state <= mem_hold;
                end
                // The requester still shows valid in the pulse cycle, so wait for it to drop.
                mem_hold:
                begin
                    if (!mem_req_valid && !mem_req_ready)
                        state <= mem_idle;
                end
                default: state <= mem_idle;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (load_en)
            mem[load_addr] <= load_data;
        if (fire)
            mem_req_data <= mem[mem_req_addr];
    end

endmodule

//--- tests/fetch_assertions.sv
`timescale 1ns/1ps

module fetch_assertions (
    input logic                    clk,
    input logic                    rst,
    input logic                    cpu_req_ready,
    input logic                    mem_req_valid,
    input logic                    mem_req_ready,
    input logic                    hit,
    input fetch_pkg::cache_state_t state
);
    import fetch_pkg::*;

    int failures = 0;

    // The answer to the fetch unit is a single-cycle pulse.
    ready_is_pulse: assert property (@(posedge clk) disable iff (rst)
        cpu_req_ready |=> !cpu_req_ready)
    else
    begin
        failures++;
        $error("cpu_req_ready stayed high for two cycles");
    end

    fill_request_held: assert property (@(posedge clk) disable iff (rst)
        mem_req_valid && !mem_req_ready |=> mem_req_valid)
    else
    begin
        failures++;
        $error("mem_req_valid dropped before mem_req_ready");
    end

    // A completed fill makes the next compare hit, and that hit answers at the following edge.
    fill_then_hit: assert property (@(posedge clk) disable iff (rst)
        (state == st_allocate) && mem_req_ready
            |=> ((state == st_compare) && hit) ##1 cpu_req_ready)
    else
    begin
        failures++;
        $error("a filled line did not hit in compare and answer with cpu_req_ready");
    end

endmodule

bind i_cache fetch_assertions u_assertions (
    .clk           (clk),
    .rst           (rst),
    .cpu_req_ready (cpu_req_ready),
    .mem_req_valid (mem_req_valid),
    .mem_req_ready (mem_req_ready),
    .hit           (hit),
    .state         (state)
);

//--- tests/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb;
    import fetch_pkg::*;

    localparam int INDEX_BITS  = 4;
    localparam int MEM_LATENCY = 3;

    logic  clk;
    logic  rst;
    logic  run;
    logic  redirect_valid;
    addr_t redirect_pc;
    logic  flush;
    logic  load_en;
    addr_t load_addr;
    word_t load_data;
    logic  inst_valid;
    addr_t inst_pc;
    word_t inst_data;
    logic  busy;

    logic [31:0]               lfsr = 32'd7308;
    word_t                     mem_model [65536];
    addr_t                     line_model [1 << INDEX_BITS];
    logic [(1<<INDEX_BITS)-1:0] valid_model = '0;
    addr_t                     exp_pc = '0;
    bit                        model_ok = 1'b1;
    bit                        streak = 1'b0;
    logic                      run_q = 1'b0;
    int                        cycle = 0;
    int                        last_cycle = 0;
    int                        fetches = 0;
    int                        hit_checks = 0;
    int                        miss_checks = 0;
    int                        busy_redirects = 0;

    fetch_top #(
        .INDEX_BITS  (INDEX_BITS),
        .MEM_LATENCY (MEM_LATENCY)
    ) i_dut (.*);

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected)
        begin
            $display("error at time %0t: %s, got %h, expected %h", $time, what, actual, expected);
            $display("STATUS: FAIL");
            $fatal(1, "simulation stopped at the first error");
        end
    endtask

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped after a timeout");
    endtask

    // Galois LFSR, one step per bit handed out.
    function automatic logic [31:0] take_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++)
        begin
            lfsr  = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            value = {value[30:0], lfsr[0]};
        end
        return value;
    endfunction

    // Reference model. Cache state is only trusted while no request can have been dropped.
    always @(posedge clk)
    begin
        logic [INDEX_BITS-1:0] idx;
        cycle = cycle + 1;
        if (rst)
        begin
            valid_model = '0;
            model_ok    = 1'b1;
            exp_pc      = '0;
            streak      = 1'b0;
            run_q       = 1'b0;
        end
        else
        begin
            if (load_en)
                mem_model[load_addr] = load_data;
            if (inst_valid)
            begin
                check_value(32'(inst_pc), 32'(exp_pc), "inst_pc");
                check_value(inst_data, mem_model[exp_pc], "inst_data");
                idx = exp_pc[INDEX_BITS-1:0];
                if (model_ok && streak)
                begin
                    if (valid_model[idx] && line_model[idx] == exp_pc)
                    begin
                        check_value(32'(cycle - last_cycle), 32'd3, "spacing of a cache hit");
                        hit_checks++;
                    end
                    else
                    begin
                        check_value(32'(cycle - last_cycle > 3), 32'd1, "spacing of a cache miss");
                        miss_checks++;
                    end
                end
                valid_model[idx] = 1'b1;
                line_model[idx]  = exp_pc;
                exp_pc           = exp_pc + addr_t'(1);
                last_cycle       = cycle;
                fetches++;
            end
            if (flush)
            begin
                valid_model = '0;
                model_ok    = 1'b1;
            end
            if (redirect_valid)
            begin
                exp_pc = redirect_pc;
                streak = 1'b0;
                if (run)
                    model_ok = 1'b0;
                if (busy)
                    busy_redirects++;
            end
            else if (run && !run_q)
            begin
                // The first strobe is sampled at this edge, like a strobe after a pulse.
                streak     = 1'b1;
                last_cycle = cycle;
            end
            if (!run)
                streak = 1'b0;
            run_q = run;
        end
    end

    task automatic load_words(input int first, input int count);
        for (int i = 0; i < count; i++)
        begin
            @(negedge clk);
            check_value(32'({inst_valid, busy}), 32'd0, "inst_valid or busy while run is low");
            load_en   = 1'b1;
            load_addr = addr_t'(first + i);
            load_data = take_bits(32);
        end
        @(negedge clk);
        load_en = 1'b0;
    endtask

    task automatic wait_fetches(input int count);
        int target;
        int waited;
        target = fetches + count;
        waited = 0;
        while (fetches < target)
        begin
            @(negedge clk);
            waited++;
            if (waited > 50 * count)
                fail_run("timeout: inst_valid stopped arriving");
        end
    endtask

    task automatic wait_idle();
        int waited;
        waited = 0;
        while (busy)
        begin
            @(negedge clk);
            waited++;
            if (waited > 100)
                fail_run("timeout: busy never went low after run was dropped");
        end
    endtask

    // Redirect with fetching stopped, then run until count words have come back.
    task automatic fetch_from(input addr_t pc, input int count);
        @(negedge clk);
        redirect_valid = 1'b1;
        redirect_pc    = pc;
        @(negedge clk);
        redirect_valid = 1'b0;
        run            = 1'b1;
        wait_fetches(count);
        @(negedge clk);
        run = 1'b0;
        wait_idle();
    endtask

    initial
    begin
        int since;
        rst            = 1'b1;
        run            = 1'b0;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        flush          = 1'b0;
        load_en        = 1'b0;
        load_addr      = '0;
        load_data      = '0;
        repeat (8) @(negedge clk);
        rst = 1'b0;

        load_words(0, 256);
        fetch_from(16'd0, 20);
        fetch_from(16'd4, 10);
        // Addresses 32 and 33 evict 16 and 17 from lines 0 and 1.
        fetch_from(16'd32, 2);
        fetch_from(16'd16, 2);

        @(negedge clk);
        run   = 1'b1;
        since = 0;
        for (int i = 0; i < 400; i++)
        begin
            @(negedge clk);
            since++;
            redirect_valid = (take_bits(3) == 32'd0) || (since > 30);
            if (redirect_valid)
            begin
                redirect_pc = addr_t'(take_bits(7));
                since       = 0;
            end
        end
        @(negedge clk);
        redirect_valid = 1'b0;
        run            = 1'b0;
        wait_idle();

        load_words(0, 64);
        @(negedge clk);
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        fetch_from(16'd0, 24);

        check_value(32'(hit_checks > 0), 32'd1, "no pair of cache hits was timed");
        check_value(32'(miss_checks > 0), 32'd1, "no cache miss was timed");
        check_value(32'(busy_redirects > 0), 32'd1, "no redirect met an outstanding request");
        if (i_dut.u_cache.u_assertions.failures == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule
